// File: logic/afu_defs.svh
`ifndef AFU_DEFS_SVH
`define AFU_DEFS_SVH

////////////////////
// host tags
////////////////////

// one busy bit per tag, all in one word
`define AFU_NUM_TAGS 8
`define AFU_TAG_W 3

////////////////////
// bus and queues
////////////////////

// credits granted by the host at reset
`define AFU_CREDITS 4
`define AFU_CMD_DEPTH 8

`define AFU_ADDR_W 32
`define AFU_CU_W 4

`endif

// File: logic/capi_pkg.sv
package capi_pkg;

	////////////////////
	// command codes
	////////////////////

	// only the two codes the compute units use
	typedef enum logic [12:0] {
		READ_CL_NA = 13'h0A00,
		WRITE_NA   = 13'h0D00
	} cmd_code_t;

	////////////////////
	// response codes
	////////////////////

	typedef enum logic [7:0] {
		// command completed
		DONE    = 8'h00,
		// address translation error
		AERROR  = 8'h01,
		// data error on the bus
		DERROR  = 8'h03,
		// lock lost
		NLOCK   = 8'h04,
		// reservation lost
		NRES    = 8'h05,
		// dropped after an earlier failure
		FLUSHED = 8'h06,
		FAULT   = 8'h07,
		FAILED  = 8'h08,
		// page fault, host wants a restart
		PAGED   = 8'h0A
	} rsp_code_t;

endpackage

// File: logic/afu_pkg.sv
`include "afu_defs.svh"

package afu_pkg;

	////////////////////
	// command types
	////////////////////

	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_type_t;

	// one entry of a command queue
	typedef struct packed {
		logic [`AFU_ADDR_W-1:0] address;
		logic [`AFU_CU_W-1:0]   cu_id;
	} cu_command_t;

	////////////////////
	// tag table
	////////////////////

	// owner of an outstanding tag
	typedef struct packed {
		cmd_type_t            cmd_type;
		logic [`AFU_CU_W-1:0] cu_id;
	} tag_entry_t;

endpackage

// File: logic/issue_if.sv
`include "afu_defs.svh"

interface issue_if;

	// command leaving the arbiter this cycle
	logic                  valid;
	afu_pkg::cmd_type_t    cmd_type;
	logic [`AFU_CU_W-1:0]  cu_id;

	// lowest free tag and whether there is one
	logic [`AFU_TAG_W-1:0] tag;
	logic                  tag_ready;

	modport arbiter (
		output valid,
		output cmd_type,
		output cu_id,
		input  tag,
		input  tag_ready
	);

	modport tags (
		input  valid,
		input  cmd_type,
		input  cu_id,
		output tag,
		output tag_ready
	);

endinterface

// File: logic/cmd_fifo.sv
`include "afu_defs.svh"

module cmd_fifo (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 push,
	input  afu_pkg::cu_command_t data_in,
	input  logic                 pop,
	output afu_pkg::cu_command_t data_out,
	output logic                 empty,
	output logic                 full
);

	localparam int PTR_W = $clog2(`AFU_CMD_DEPTH);

	afu_pkg::cu_command_t mem [`AFU_CMD_DEPTH];

	// extra top bit tells full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic           do_push;
	logic           do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	// push into a full queue is dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// head is visible without a pop
	assign data_out = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr[PTR_W-1:0]] <= data_in;
		end
	end

endmodule

// File: logic/command_arbiter.sv
`include "afu_defs.svh"

module command_arbiter (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   read_cmd_valid,
	input  afu_pkg::cu_command_t   read_cmd,
	input  logic                   write_cmd_valid,
	input  afu_pkg::cu_command_t   write_cmd,
	output logic                   read_full,
	output logic                   write_full,
	input  logic                   response_valid,
	input  logic [1:0]             response_credits,
	issue_if.arbiter               issue,
	output logic                   command_valid,
	output capi_pkg::cmd_code_t    command_code,
	output logic [`AFU_TAG_W-1:0]  command_tag,
	output logic [`AFU_ADDR_W-1:0] command_address,
	output logic [`AFU_CU_W-1:0]   command_cu_id
);

	// room above the reset value for late returns
	localparam int CREDIT_W = $clog2(`AFU_CREDITS) + 2;

	afu_pkg::cu_command_t read_head;
	afu_pkg::cu_command_t write_head;
	logic                 read_empty;
	logic                 write_empty;
	logic                 can_issue;
	logic                 read_req;
	logic                 write_req;
	logic                 grant_read;
	logic                 grant_write;
	logic                 last_write;
	logic [CREDIT_W-1:0]  credits;
	logic [CREDIT_W-1:0]  credit_back;

	////////////////////
	// command queues
	////////////////////

	cmd_fifo read_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (read_cmd_valid),
		.data_in (read_cmd),
		.pop     (grant_read),
		.data_out(read_head),
		.empty   (read_empty),
		.full    (read_full)
	);

	cmd_fifo write_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (write_cmd_valid),
		.data_in (write_cmd),
		.pop     (grant_write),
		.data_out(write_head),
		.empty   (write_empty),
		.full    (write_full)
	);

	////////////////////
	// round robin
	////////////////////

	// a request needs a credit and a free tag
	assign can_issue = enabled && issue.tag_ready && (credits != '0);
	assign read_req = can_issue && !read_empty;
	assign write_req = can_issue && !write_empty;

	// on a tie the queue that lost last time wins
	assign grant_read = read_req && (!write_req || last_write);
	assign grant_write = write_req && !grant_read;

	assign issue.valid = grant_read || grant_write;
	assign issue.cmd_type = grant_write ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ;
	assign issue.cu_id = grant_write ? write_head.cu_id : read_head.cu_id;

	assign credit_back = (enabled && response_valid) ? CREDIT_W'(response_credits) : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
			last_write <= 1'b1;
			credits <= CREDIT_W'(`AFU_CREDITS);
		end else begin
			command_valid <= issue.valid;
			// issue and return may land in the same cycle
			credits <= credits + credit_back - CREDIT_W'(issue.valid);
			if (issue.valid) begin
				last_write <= grant_write;
			end
		end
	end

	////////////////////
	// command register
	////////////////////

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			command_code <= grant_write ? capi_pkg::WRITE_NA : capi_pkg::READ_CL_NA;
			command_tag <= issue.tag;
			command_address <= grant_write ? write_head.address : read_head.address;
			command_cu_id <= issue.cu_id;
		end
	end

endmodule

// File: logic/tag_control.sv
`include "afu_defs.svh"

module tag_control (
	input  logic                  clock,
	input  logic                  rstn,
	issue_if.tags                 issue,
	input  logic [`AFU_TAG_W-1:0] lookup_tag,
	output afu_pkg::tag_entry_t   lookup_entry,
	input  logic                  tag_release
);

	// one bit per tag, set while the tag is outstanding
	logic [`AFU_NUM_TAGS-1:0] busy;
	logic [`AFU_TAG_W-1:0]    free_tag;

	afu_pkg::tag_entry_t table_mem [`AFU_NUM_TAGS];

	////////////////////
	// free tag pool
	////////////////////

	// walk down so the lowest free tag is the one left
	always_comb begin
		free_tag = '0;
		for (int i = `AFU_NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_tag = `AFU_TAG_W'(i);
			end
		end
	end

	assign issue.tag = free_tag;
	assign issue.tag_ready = ~&busy;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			// released tag is busy, issued one is free, so they never collide
			if (tag_release) begin
				busy[lookup_tag] <= 1'b0;
			end
			if (issue.valid) begin
				busy[issue.tag] <= 1'b1;
			end
		end
	end

	////////////////////
	// tag table
	////////////////////

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			table_mem[issue.tag].cmd_type <= issue.cmd_type;
			table_mem[issue.tag].cu_id <= issue.cu_id;
		end
	end

	assign lookup_entry = table_mem[lookup_tag];

endmodule

// File: logic/response_control.sv
`include "afu_defs.svh"

module response_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  logic                  response_valid,
	input  logic [`AFU_TAG_W-1:0] response_tag,
	input  capi_pkg::rsp_code_t   response_code,
	output logic [`AFU_TAG_W-1:0] lookup_tag,
	input  afu_pkg::tag_entry_t   lookup_entry,
	output logic                  tag_release,
	output logic                  read_response_valid,
	output logic                  write_response_valid,
	output logic                  response_error,
	output logic [`AFU_CU_W-1:0]  response_cu_id,
	output capi_pkg::rsp_code_t   error_code
);

	logic                  s1_valid;
	logic [`AFU_TAG_W-1:0] s1_tag;
	capi_pkg::rsp_code_t   s1_code;
	logic                  s2_valid;
	logic [`AFU_TAG_W-1:0] s2_tag;
	capi_pkg::rsp_code_t   s2_code;
	logic                  done_class;

	////////////////////
	// stage one and two
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= enabled && response_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		s1_tag <= response_tag;
		s1_code <= response_code;
		s2_tag <= s1_tag;
		s2_code <= s1_code;
	end

	// everything else is an error
	always_comb begin
		case (s2_code)
			capi_pkg::DONE, capi_pkg::NLOCK, capi_pkg::NRES, capi_pkg::FAILED:
				done_class = 1'b1;
			default:
				done_class = 1'b0;
		endcase
	end

	// tag is freed whatever the class
	assign lookup_tag = s2_tag;
	assign tag_release = s2_valid;

	////////////////////
	// routed outputs
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_valid <= 1'b0;
			write_response_valid <= 1'b0;
			response_error <= 1'b0;
		end else begin
			read_response_valid <= s2_valid && done_class &&
				(lookup_entry.cmd_type == afu_pkg::CMD_READ);
			write_response_valid <= s2_valid && done_class &&
				(lookup_entry.cmd_type == afu_pkg::CMD_WRITE);
			response_error <= s2_valid && !done_class;
		end
	end

	always_ff @(posedge clock) begin
		response_cu_id <= lookup_entry.cu_id;
		error_code <= s2_code;
	end

endmodule

// File: logic/afu_control.sv
`include "afu_defs.svh"

module afu_control (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  logic                   read_cmd_valid,
	input  logic [`AFU_ADDR_W-1:0] read_cmd_address,
	input  logic [`AFU_CU_W-1:0]   read_cmd_cu_id,
	input  logic                   write_cmd_valid,
	input  logic [`AFU_ADDR_W-1:0] write_cmd_address,
	input  logic [`AFU_CU_W-1:0]   write_cmd_cu_id,
	output logic                   read_full,
	output logic                   write_full,
	output logic                   command_valid,
	output capi_pkg::cmd_code_t    command_code,
	output logic [`AFU_TAG_W-1:0]  command_tag,
	output logic [`AFU_ADDR_W-1:0] command_address,
	output logic [`AFU_CU_W-1:0]   command_cu_id,
	input  logic                   response_valid,
	input  logic [`AFU_TAG_W-1:0]  response_tag,
	input  capi_pkg::rsp_code_t    response_code,
	input  logic [1:0]             response_credits,
	output logic                   read_response_valid,
	output logic                   write_response_valid,
	output logic                   response_error,
	output logic [`AFU_CU_W-1:0]   response_cu_id,
	output capi_pkg::rsp_code_t    error_code
);

	logic                  enabled;
	afu_pkg::cu_command_t  read_cmd;
	afu_pkg::cu_command_t  write_cmd;
	logic [`AFU_TAG_W-1:0] lookup_tag;
	afu_pkg::tag_entry_t   lookup_entry;
	logic                  tag_release;

	issue_if issue_bus ();

	////////////////////
	// enable
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	assign read_cmd.address = read_cmd_address;
	assign read_cmd.cu_id = read_cmd_cu_id;
	assign write_cmd.address = write_cmd_address;
	assign write_cmd.cu_id = write_cmd_cu_id;

	////////////////////
	// command path
	////////////////////

	command_arbiter command_arbiter_inst (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd        (read_cmd),
		.write_cmd_valid (write_cmd_valid),
		.write_cmd       (write_cmd),
		.read_full       (read_full),
		.write_full      (write_full),
		.response_valid  (response_valid),
		.response_credits(response_credits),
		.issue           (issue_bus.arbiter),
		.command_valid   (command_valid),
		.command_code    (command_code),
		.command_tag     (command_tag),
		.command_address (command_address),
		.command_cu_id   (command_cu_id)
	);

	tag_control tag_control_inst (
		.clock       (clock),
		.rstn        (rstn),
		.issue       (issue_bus.tags),
		.lookup_tag  (lookup_tag),
		.lookup_entry(lookup_entry),
		.tag_release (tag_release)
	);

	////////////////////
	// response path
	////////////////////

	response_control response_control_inst (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.response_valid      (response_valid),
		.response_tag        (response_tag),
		.response_code       (response_code),
		.lookup_tag          (lookup_tag),
		.lookup_entry        (lookup_entry),
		.tag_release         (tag_release),
		.read_response_valid (read_response_valid),
		.write_response_valid(write_response_valid),
		.response_error      (response_error),
		.response_cu_id      (response_cu_id),
		.error_code          (error_code)
	);

endmodule

// File: tests/clock_gen.sv
module clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// reset held low for the first four rising edges
	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

// File: tests/afu_control_assertions.sv
`include "afu_defs.svh"

module afu_control_assertions (
	input logic       clock,
	input logic       rstn,
	input logic       enabled,
	input logic       command_valid,
	input logic       response_valid,
	input logic [1:0] response_credits,
	input logic       read_response_valid,
	input logic       write_response_valid,
	input logic       response_error
);

	// credit count as it stood before the command now on the bus
	logic [7:0] credits_before;
	logic [1:0] returned;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits_before <= 8'(`AFU_CREDITS);
			returned <= 2'd0;
		end else begin
			returned <= (enabled && response_valid) ? response_credits : 2'd0;
			credits_before <= credits_before + 8'(returned) - 8'(command_valid);
		end
	end

	////////////////////
	// properties
	////////////////////

	// issue edge is one before command_valid shows
	assert property (@(posedge clock) disable iff (!rstn)
		command_valid |-> $past(enabled))
		else $error("command issued while disabled");

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0({read_response_valid, write_response_valid, response_error}))
		else $error("more than one response output high");

	assert property (@(posedge clock) disable iff (!rstn)
		command_valid |-> (credits_before != 8'd0))
		else $error("command issued with zero credits");

endmodule

bind afu_control afu_control_assertions assertions_inst (
	.clock               (clock),
	.rstn                (rstn),
	.enabled             (enabled),
	.command_valid       (command_valid),
	.response_valid      (response_valid),
	.response_credits    (response_credits),
	.read_response_valid (read_response_valid),
	.write_response_valid(write_response_valid),
	.response_error      (response_error)
);

// File: tests/afu_control_tb.sv
`include "afu_defs.svh"

module afu_control_tb;

	localparam int TIMEOUT_CYCLES = 2000;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic                   read_cmd_valid;
	logic [`AFU_ADDR_W-1:0] read_cmd_address;
	logic [`AFU_CU_W-1:0]   read_cmd_cu_id;
	logic                   write_cmd_valid;
	logic [`AFU_ADDR_W-1:0] write_cmd_address;
	logic [`AFU_CU_W-1:0]   write_cmd_cu_id;
	logic                   read_full;
	logic                   write_full;
	logic                   command_valid;
	capi_pkg::cmd_code_t    command_code;
	logic [`AFU_TAG_W-1:0]  command_tag;
	logic [`AFU_ADDR_W-1:0] command_address;
	logic [`AFU_CU_W-1:0]   command_cu_id;
	logic                   response_valid;
	logic [`AFU_TAG_W-1:0]  response_tag;
	capi_pkg::rsp_code_t    response_code;
	logic [1:0]             response_credits;
	logic                   read_response_valid;
	logic                   write_response_valid;
	logic                   response_error;
	logic [`AFU_CU_W-1:0]   response_cu_id;
	capi_pkg::rsp_code_t    error_code;

	string                    current_test;
	int                       cycle_count;
	int                       issued_total;
	logic [`AFU_NUM_TAGS-1:0] outstanding;

	// pushed commands not yet seen on the bus, per queue
	logic [`AFU_ADDR_W-1:0] exp_read_address [$];
	logic [`AFU_CU_W-1:0]   exp_read_cu [$];
	logic [`AFU_ADDR_W-1:0] exp_write_address [$];
	logic [`AFU_CU_W-1:0]   exp_write_cu [$];

	// commands seen on the bus, oldest first
	logic [`AFU_TAG_W-1:0]  seen_tag [$];
	capi_pkg::cmd_code_t    seen_code [$];
	logic [`AFU_ADDR_W-1:0] seen_address [$];
	logic [`AFU_CU_W-1:0]   seen_cu [$];

	// checked commands waiting for a host response
	logic [`AFU_TAG_W-1:0] pending_tag [$];
	afu_pkg::cmd_type_t    pending_type [$];
	logic [`AFU_CU_W-1:0]  pending_cu [$];

	clock_gen clock_gen_inst (
		.clock(clock),
		.rstn (rstn)
	);

	afu_control DUT (.*);

	////////////////////
	// reporting
	////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
				current_test, what, expected, actual);
			abort_run("value mismatch");
		end
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	// bus monitor catching a tag handed out twice
	always @(negedge clock) begin
		if (rstn && command_valid) begin
			check_value("tag already outstanding", 64'(0), 64'(outstanding[command_tag]));
			outstanding[command_tag] = 1'b1;
			seen_tag.push_back(command_tag);
			seen_code.push_back(command_code);
			seen_address.push_back(command_address);
			seen_cu.push_back(command_cu_id);
			issued_total++;
		end
	end

	////////////////////
	// stimulus helpers
	////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic push_commands(input logic do_read, input logic [`AFU_CU_W-1:0] read_cu,
		input logic do_write, input logic [`AFU_CU_W-1:0] write_cu);
		logic [`AFU_ADDR_W-1:0] read_address;
		logic [`AFU_ADDR_W-1:0] write_address;
		read_address = $urandom();
		write_address = $urandom();
		@(posedge clock);
		read_cmd_valid <= do_read;
		read_cmd_address <= read_address;
		read_cmd_cu_id <= read_cu;
		write_cmd_valid <= do_write;
		write_cmd_address <= write_address;
		write_cmd_cu_id <= write_cu;
		if (do_read) begin
			exp_read_address.push_back(read_address);
			exp_read_cu.push_back(read_cu);
		end
		if (do_write) begin
			exp_write_address.push_back(write_address);
			exp_write_cu.push_back(write_cu);
		end
	endtask

	task automatic end_push();
		@(posedge clock);
		read_cmd_valid <= 1'b0;
		write_cmd_valid <= 1'b0;
	endtask

	// next bus command must be the head of the given queue
	task automatic expect_command(input afu_pkg::cmd_type_t cmd_type);
		capi_pkg::cmd_code_t    exp_code;
		logic [`AFU_ADDR_W-1:0] exp_address;
		logic [`AFU_CU_W-1:0]   exp_cu;
		while (seen_tag.size() == 0) begin
			@(posedge clock);
		end
		if (cmd_type == afu_pkg::CMD_WRITE) begin
			exp_code = capi_pkg::WRITE_NA;
			exp_address = exp_write_address.pop_front();
			exp_cu = exp_write_cu.pop_front();
		end else begin
			exp_code = capi_pkg::READ_CL_NA;
			exp_address = exp_read_address.pop_front();
			exp_cu = exp_read_cu.pop_front();
		end
		check_value("command code", 64'(exp_code), 64'(seen_code.pop_front()));
		check_value("command address", 64'(exp_address), 64'(seen_address.pop_front()));
		check_value("command cu id", 64'(exp_cu), 64'(seen_cu.pop_front()));
		pending_tag.push_back(seen_tag.pop_front());
		pending_type.push_back(cmd_type);
		pending_cu.push_back(exp_cu);
	endtask

	task automatic check_route(input logic exp_read, input logic exp_write,
		input logic exp_error);
		check_value("read response", 64'(exp_read), 64'(read_response_valid));
		check_value("write response", 64'(exp_write), 64'(write_response_valid));
		check_value("response error", 64'(exp_error), 64'(response_error));
	endtask

	// host model answering the oldest command with one credit
	task automatic answer_oldest(input capi_pkg::rsp_code_t code);
		logic [`AFU_TAG_W-1:0] tag;
		afu_pkg::cmd_type_t    cmd_type;
		logic [`AFU_CU_W-1:0]  cu;
		logic                  done_class;
		tag = pending_tag.pop_front();
		cmd_type = pending_type.pop_front();
		cu = pending_cu.pop_front();
		// these four complete the command, anything else is an error
		done_class = (code == capi_pkg::DONE) || (code == capi_pkg::NLOCK) ||
			(code == capi_pkg::NRES) || (code == capi_pkg::FAILED);
		@(posedge clock);
		outstanding[tag] = 1'b0;
		response_valid <= 1'b1;
		response_tag <= tag;
		response_code <= code;
		response_credits <= 2'd1;
		@(posedge clock);
		response_valid <= 1'b0;
		// quiet for two edges, pulse after the third
		repeat (2) begin
			@(negedge clock);
			check_route(1'b0, 1'b0, 1'b0);
		end
		@(negedge clock);
		check_route(done_class && (cmd_type == afu_pkg::CMD_READ),
			done_class && (cmd_type == afu_pkg::CMD_WRITE), !done_class);
		if (done_class) begin
			check_value("response cu id", 64'(cu), 64'(response_cu_id));
		end else begin
			check_value("error code", 64'(code), 64'(error_code));
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic single_read_test();
		current_test = "single_read";
		push_commands(1'b1, 4'h5, 1'b0, 4'h0);
		end_push();
		expect_command(afu_pkg::CMD_READ);
		// all tags free after reset, so the lowest one goes out
		check_value("command tag", 64'(0), 64'(pending_tag[0]));
		answer_oldest(capi_pkg::DONE);
	endtask

	task automatic alternation_test();
		current_test = "alternation";
		for (int i = 0; i < 3; i++) begin
			push_commands(1'b1, 4'(i + 1), 1'b1, 4'(i + 8));
		end
		end_push();
		// a read won last, so writes lead
		for (int i = 0; i < 4; i++) begin
			expect_command((i % 2 == 0) ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ);
		end
		answer_oldest(capi_pkg::DONE);
		expect_command(afu_pkg::CMD_WRITE);
		answer_oldest(capi_pkg::DONE);
		expect_command(afu_pkg::CMD_READ);
		repeat (4) answer_oldest(capi_pkg::DONE);
	endtask

	task automatic credit_limit_test();
		int base;
		current_test = "credit_limit";
		base = issued_total;
		for (int i = 0; i < 6; i++) begin
			push_commands(1'b1, 4'(i), 1'b0, 4'h0);
		end
		end_push();
		idle_cycles(20);
		check_value("issued without responses", 64'(base + `AFU_CREDITS), 64'(issued_total));
		repeat (`AFU_CREDITS) expect_command(afu_pkg::CMD_READ);
		for (int k = 1; k <= 2; k++) begin
			answer_oldest(capi_pkg::DONE);
			idle_cycles(5);
			check_value("issued after one credit", 64'(base + `AFU_CREDITS + k),
				64'(issued_total));
			expect_command(afu_pkg::CMD_READ);
		end
		repeat (4) answer_oldest(capi_pkg::DONE);
	endtask

	task automatic code_class_test();
		current_test = "code_class";
		push_commands(1'b1, 4'h2, 1'b1, 4'h3);
		push_commands(1'b1, 4'h4, 1'b1, 4'h6);
		end_push();
		expect_command(afu_pkg::CMD_WRITE);
		expect_command(afu_pkg::CMD_READ);
		expect_command(afu_pkg::CMD_WRITE);
		expect_command(afu_pkg::CMD_READ);
		answer_oldest(capi_pkg::NLOCK);
		answer_oldest(capi_pkg::FAILED);
		answer_oldest(capi_pkg::AERROR);
		answer_oldest(capi_pkg::PAGED);
		// freed tags and credits let new work through
		push_commands(1'b1, 4'h9, 1'b1, 4'hc);
		end_push();
		expect_command(afu_pkg::CMD_WRITE);
		expect_command(afu_pkg::CMD_READ);
		answer_oldest(capi_pkg::NRES);
		answer_oldest(capi_pkg::DERROR);
	endtask

	task automatic enable_test();
		int base;
		current_test = "enable";
		base = issued_total;
		@(posedge clock);
		enabled_in <= 1'b0;
		// both queues filled while nothing can issue
		for (int i = 0; i < `AFU_CMD_DEPTH; i++) begin
			push_commands(1'b1, 4'(i), 1'b1, 4'(i + 8));
		end
		end_push();
		idle_cycles(10);
		check_value("issued while disabled", 64'(base), 64'(issued_total));
		check_value("read queue full", 64'(1), 64'(read_full));
		check_value("write queue full", 64'(1), 64'(write_full));
		@(posedge clock);
		enabled_in <= 1'b1;
		// both queues hold work throughout, so writes and reads take turns
		for (int i = 0; i < 2 * `AFU_CMD_DEPTH; i++) begin
			expect_command((i % 2 == 0) ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ);
			if (i >= `AFU_CREDITS - 1) begin
				answer_oldest(capi_pkg::DONE);
			end
		end
		repeat (`AFU_CREDITS - 1) answer_oldest(capi_pkg::DONE);
		check_value("read queue full after drain", 64'(0), 64'(read_full));
		check_value("write queue full after drain", 64'(0), 64'(write_full));
	endtask

	initial begin
		void'($urandom(32'h3a5));
		cycle_count = 0;
		issued_total = 0;
		outstanding = '0;
		current_test = "reset";
		enabled_in <= 1'b0;
		read_cmd_valid <= 1'b0;
		read_cmd_address <= '0;
		read_cmd_cu_id <= '0;
		write_cmd_valid <= 1'b0;
		write_cmd_address <= '0;
		write_cmd_cu_id <= '0;
		response_valid <= 1'b0;
		response_tag <= '0;
		response_code <= capi_pkg::DONE;
		response_credits <= 2'd0;
		wait (rstn === 1'b1);
		@(posedge clock);
		enabled_in <= 1'b1;
		idle_cycles(2);
		single_read_test();
		alternation_test();
		credit_limit_test();
		code_class_test();
		enable_test();
		idle_cycles(5);
		current_test = "final";
		check_value("tags still outstanding", 64'(0), 64'(outstanding));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/capi_pkg.sv
logic/afu_pkg.sv
logic/issue_if.sv
logic/cmd_fifo.sv
logic/command_arbiter.sv
logic/tag_control.sv
logic/response_control.sv
logic/afu_control.sv
tests/clock_gen.sv
tests/afu_control_assertions.sv
tests/afu_control_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module afu_control_tb \
	-f verilog.f \
	-o afu_control_sim

./obj_dir/afu_control_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
